/* rtl/tone_pkg.sv */
// Tone timer shared definitions
`default_nettype none

package tone_pkg;

  //////////////////////////////////////////////////
  // phase generator

  localparam int                 PHASE_STEPS = 8;   // CLK cycles per phase cycle
  localparam int                 PHASE_W     = 3;
  localparam logic [PHASE_W-1:0] PHASE_CP1   = 3'd7; // main tick
  localparam logic [PHASE_W-1:0] PHASE_CP2   = 3'd4; // pending set window
  localparam logic [PHASE_W-1:0] PHASE_CLK1  = 3'd2; // N load window

  //////////////////////////////////////////////////
  // tone divider

  localparam int             N_W   = 8;
  localparam int             NUC_W = 3;

  localparam logic [N_W-1:0] RANGE_08_MIN = 8'h08; // lower bounds of the N classes
  localparam logic [N_W-1:0] RANGE_10_MIN = 8'h10;
  localparam logic [N_W-1:0] RANGE_20_MIN = 8'h20;
  localparam logic [N_W-1:0] RANGE_40_MIN = 8'h40;

  //////////////////////////////////////////////////
  // interrupt vector and mode word

  localparam int               VEC_W          = 12;
  localparam logic [VEC_W-1:0] VEC_TONE_BASE  = 12'h020;
  localparam logic [VEC_W-1:0] VEC_STEP       = 12'h004; // added per range index
  localparam int               MD_TONE_IE_BIT = 1;

  typedef enum logic [2:0] {
    R_OFF = 3'd0,  // below 08, no tone
    R_08  = 3'd1,
    R_10  = 3'd2,
    R_20  = 3'd3,
    R_40  = 3'd4
  } range_e;

  typedef struct packed {
    logic cp1;   // main tick
    logic cp2;   // second phase window
    logic clk1;  // N load window
    logic res;   // internal reset
  } phase_t;

  typedef struct packed {
    logic           n_wr;
    logic           md_wr;
    logic           reti;
    logic [N_W-1:0] data;
  } host_req_t;

  typedef struct packed {
    logic   trig;  // one tick after a falling tone edge
    range_e rng;
  } tone_evt_t;

  typedef struct packed {
    logic             load;
    logic             active;
    logic [VEC_W-1:0] vec;
  } irq_t;

endpackage

`default_nettype wire

/* rtl/clock_phase_gen.sv */
// Clock phase generator
`default_nettype none

module clock_phase_gen
  import tone_pkg::*;
(
  input  logic   CLK,
  input  logic   rst_n,
  output phase_t phase
);

  logic [PHASE_W-1:0] step;      // position in the phase cycle
  logic [PHASE_W-1:0] step_nxt;
  logic               cp1_q;
  logic               cp2_q;
  logic               clk1_q;
  logic               res_q;

  //////////////////////////////////////////////////
  // step counter

  assign step_nxt = (step == PHASE_W'(PHASE_STEPS - 1)) ? '0 : step + 1'b1;

  // strobes are registered from the next step, so each one is
  // high exactly while the counter sits on its own step
  always_ff @(posedge CLK) begin
    if (!rst_n) begin
      step   <= '0;
      cp1_q  <= 1'b0;
      cp2_q  <= 1'b0;
      clk1_q <= 1'b0;
    end else begin
      step   <= step_nxt;
      cp1_q  <= (step_nxt == PHASE_CP1);
      cp2_q  <= (step_nxt == PHASE_CP2);
      clk1_q <= (step_nxt == PHASE_CLK1);
    end
  end

  //////////////////////////////////////////////////
  // internal reset

  // held through rst_n, dropped on the first tick after it
  always_ff @(posedge CLK) begin
    if (!rst_n) begin
      res_q <= 1'b1;
    end else if (cp1_q) begin
      res_q <= 1'b0;  // release lines up with the tick
    end
  end

  always_comb begin
    phase.cp1  = cp1_q;
    phase.cp2  = cp2_q;
    phase.clk1 = clk1_q;
    phase.res  = res_q;
  end

endmodule

`default_nettype wire

/* rtl/tone_divider.sv */
// Tone divider
`default_nettype none

module tone_divider
  import tone_pkg::*;
(
  input  logic      CLK,
  input  phase_t    phase,
  input  host_req_t host,
  output tone_evt_t evt
);

  logic [N_W-1:0]   n;          // reload value
  logic [N_W-1:0]   n_hold;     // written value waiting for clk1
  logic             n_pend;
  logic [N_W-1:0]   nc;         // down-counter
  logic [NUC_W-1:0] nuc;        // reload counter
  logic             nc_eq_01;
  logic             reload_d;   // reload flag, one tick late
  range_e           rng;
  logic             tone_cond;
  logic             tone_cond_d;
  logic             trig_q;

  //////////////////////////////////////////////////
  // N register

  always_ff @(posedge CLK) begin
    if (host.n_wr) begin
      n_hold <= host.data;
    end
  end

  always_ff @(posedge CLK) begin
    if (phase.res) begin
      n      <= '0;
      n_pend <= 1'b0;
    end else begin
      if (phase.clk1 && n_pend) begin
        n <= n_hold;
      end
      if (host.n_wr) begin
        n_pend <= 1'b1;  // a new write waits for the next window
      end else if (phase.clk1) begin
        n_pend <= 1'b0;
      end
    end
  end

  //////////////////////////////////////////////////
  // NC and NUC counters

  assign nc_eq_01 = (nc == N_W'(1));

  always_ff @(posedge CLK) begin
    if (phase.cp1) begin
      if (phase.res) begin
        nc       <= '0;
        nuc      <= '0;
        reload_d <= 1'b0;
      end else begin
        nc       <= nc_eq_01 ? n : nc - 1'b1;
        reload_d <= nc_eq_01;
        if (reload_d) begin
          nuc <= nuc + 1'b1;  // counts reloads
        end
      end
    end
  end

  //////////////////////////////////////////////////
  // range class and tone trigger

  always_comb begin
    if (n < RANGE_08_MIN)      rng = R_OFF;
    else if (n < RANGE_10_MIN) rng = R_08;
    else if (n < RANGE_20_MIN) rng = R_10;
    else if (n < RANGE_40_MIN) rng = R_20;  // 3f included
    else                       rng = R_40;
  end

  // slower classes take higher NUC bits
  always_comb begin
    case (rng)
      R_08:    tone_cond = nuc[2];
      R_10:    tone_cond = nuc[1];
      R_20:    tone_cond = nuc[0];
      R_40:    tone_cond = reload_d;
      default: tone_cond = 1'b0;
    endcase
  end

  always_ff @(posedge CLK) begin
    if (phase.cp1) begin
      if (phase.res) begin
        tone_cond_d <= 1'b0;
        trig_q      <= 1'b0;
      end else begin
        tone_cond_d <= tone_cond;
        trig_q      <= tone_cond_d & ~tone_cond;  // falling edge
      end
    end
  end

  always_comb begin
    evt.trig = trig_q;
    evt.rng  = rng;
  end

endmodule

`default_nettype wire

/* rtl/tone_int_ctrl.sv */
// Tone interrupt controller
`default_nettype none

module tone_int_ctrl
  import tone_pkg::*;
(
  input  logic      CLK,
  input  phase_t    phase,
  input  host_req_t host,
  input  tone_evt_t evt,
  output irq_t      irq
);

  logic             tone_ie;     // mode bit
  logic             pending;
  logic             active;
  logic             active_nxt;
  logic             set_active;
  logic             reti_pend;   // return seen, acts on the next tick
  logic             reti_req;
  logic             load_q;
  logic [1:0]       rng_idx;
  logic [VEC_W-1:0] vec_tone;

  //////////////////////////////////////////////////
  // mode bit

  always_ff @(posedge CLK) begin
    if (phase.res) begin
      tone_ie <= 1'b0;
    end else if (host.md_wr) begin
      tone_ie <= host.data[MD_TONE_IE_BIT];
    end
  end

  //////////////////////////////////////////////////
  // pending and active

  assign set_active = pending & ~active;
  assign reti_req   = reti_pend | host.reti;
  assign active_nxt = (active | set_active) & ~reti_req;

  always_ff @(posedge CLK) begin
    if (phase.res) begin
      pending <= 1'b0;
    end else if (phase.cp1 && set_active) begin
      pending <= 1'b0;  // handed over to active
    end else if (phase.cp2 && evt.trig && tone_ie && !active) begin
      pending <= 1'b1;
    end
  end

  always_ff @(posedge CLK) begin
    if (phase.res) begin
      reti_pend <= 1'b0;
    end else if (phase.cp1) begin
      reti_pend <= 1'b0;
    end else if (host.reti) begin
      reti_pend <= 1'b1;
    end
  end

  // trig while in service is dropped, pending only sets when idle
  always_ff @(posedge CLK) begin
    if (phase.res) begin
      active <= 1'b0;
      load_q <= 1'b0;
    end else if (phase.cp1) begin
      active <= active_nxt;
      load_q <= active_nxt & ~active;  // one tick on the rise
    end
  end

  //////////////////////////////////////////////////
  // vector

  always_comb begin
    case (evt.rng)
      R_10:    rng_idx = 2'd1;
      R_20:    rng_idx = 2'd2;
      R_40:    rng_idx = 2'd3;
      default: rng_idx = 2'd0;  // R_08 shares the base
    endcase
  end

  assign vec_tone = VEC_TONE_BASE + VEC_STEP * VEC_W'(rng_idx);

  always_comb begin
    irq.load   = load_q;
    irq.active = active;
    irq.vec    = load_q ? vec_tone : '0;
  end

endmodule

`default_nettype wire

/* rtl/tone_timer_top.sv */
// Tone timer top level
`default_nettype none

module tone_timer_top
  import tone_pkg::*;
(
  input  logic      CLK,
  input  logic      rst_n,
  input  host_req_t host,
  output irq_t      irq
);

  phase_t    phase;  // strobes and internal reset
  tone_evt_t evt;    // divider to controller

  //////////////////////////////////////////////////
  // phase strobes

  clock_phase_gen i_clock_phase_gen (
    .CLK   (CLK),
    .rst_n (rst_n),
    .phase (phase)
  );

  //////////////////////////////////////////////////
  // tone divider

  tone_divider i_tone_divider (
    .CLK   (CLK),
    .phase (phase),
    .host  (host),
    .evt   (evt)
  );

  //////////////////////////////////////////////////
  // interrupt controller

  // trig from the divider is the only interrupt source
  tone_int_ctrl i_tone_int_ctrl (
    .CLK   (CLK),
    .phase (phase),
    .host  (host),
    .evt   (evt),
    .irq   (irq)
  );

endmodule

`default_nettype wire

/* tb/tone_timer_assertions.sv */
// Interrupt controller checks
`default_nettype none

module tone_timer_assertions
  import tone_pkg::*;
(
  input logic   CLK,
  input phase_t phase,
  input logic   active,
  input irq_t   irq
);

  int fail_count = 0;  // failed checks so far

  //////////////////////////////////////////////////
  // load against active

  load_needs_rise: assert property (
    @(posedge CLK) disable iff (phase.res !== 1'b0)
    $rose(irq.load) |-> $rose(active)
  ) else begin
    $error("load rose without a rise of active");
    fail_count++;
  end

  // a second activation during service
  no_reentry: assert property (
    @(posedge CLK) disable iff (phase.res !== 1'b0)
    $past(active) |-> !$rose(irq.load)
  ) else begin
    $error("load rose again while the interrupt was still active");
    fail_count++;
  end

  //////////////////////////////////////////////////
  // vector

  vec_with_load: assert property (
    @(posedge CLK) disable iff (phase.res !== 1'b0)
    (irq.vec != '0) == irq.load
  ) else begin
    $error("vec non-zero does not match load");
    fail_count++;
  end

endmodule

bind tone_int_ctrl tone_timer_assertions i_assertions (
  .CLK    (CLK),
  .phase  (phase),
  .active (active),
  .irq    (irq)
);

`default_nettype wire

/* tb/tone_timer_tb.sv */
// Tone timer testbench
`default_nettype none

module tone_timer_tb
  import tone_pkg::*;
();

  localparam int NC_WRAP      = 256 * PHASE_STEPS;  // longest NC run after a change
  localparam int LONGEST      = 8 * 127;            // R_40 with the largest N picked
  localparam int WATCHDOG_CLK = 4 * (300 + 4 * (NC_WRAP + 5 * LONGEST)
                                + 5 * (NC_WRAP + 2 * LONGEST) + NC_WRAP + 8 * LONGEST);

  logic             CLK;
  logic             rst_n;
  host_req_t        host;
  irq_t             irq;
  logic [7:0]       lfsr_state = 8'd29;
  string            test_name  = "init";
  int               err_count  = 0;
  int               cycle      = 0;     // negedge count
  int               load_count = 0;
  int               last_rise  = 0;     // cycle of the latest load rise
  logic             load_seen  = 1'b0;
  logic             quiet      = 1'b0;  // any load rise is wrong
  logic             vec_chk    = 1'b0;
  logic [VEC_W-1:0] exp_vec    = '0;

  tone_timer_top i_dut (
    .CLK   (CLK),
    .rst_n (rst_n),
    .host  (host),
    .irq   (irq)
  );

  always #20 CLK = ~CLK;

  //////////////////////////////////////////////////
  // reference model

  // 8-bit Fibonacci LFSR with taps 8 6 5 4
  function automatic logic [7:0] lfsr_step(input logic [7:0] s);
    return {s[6:0], s[7] ^ s[5] ^ s[4] ^ s[3]};
  endfunction

  function automatic logic [7:0] take_bits(input int count);
    logic [7:0] bits;
    bits = '0;
    for (int i = 0; i < count; i++) begin
      lfsr_state = lfsr_step(lfsr_state);
      bits       = {bits[6:0], lfsr_state[0]};
    end
    return bits;
  endfunction

  // 0 off, 1 08-0f, 2 10-1f, 3 20-3f, 4 40 and up
  function automatic int range_class(input logic [N_W-1:0] n);
    if (n >= 8'h40) return 4;
    if (n >= 8'h20) return 3;
    if (n >= 8'h10) return 2;
    if (n >= 8'h08) return 1;
    return 0;
  endfunction

  function automatic logic [N_W-1:0] pick_n(input int cls);
    case (cls)
      1:       return 8'h08 + take_bits(3);
      2:       return 8'h10 + take_bits(4);
      3:       return 8'h20 + take_bits(5);  // 3f can come up
      4:       return 8'h40 + take_bits(6);
      default: return take_bits(3);
    endcase
  endfunction

  function automatic logic [VEC_W-1:0] vec_for(input logic [N_W-1:0] n);
    int idx;
    case (range_class(n))
      2:       idx = 1;
      3:       idx = 2;
      4:       idx = 3;
      default: idx = 0;  // off and 08 share the base
    endcase
    return VEC_TONE_BASE + VEC_STEP * VEC_W'(idx);
  endfunction

  function automatic int interval_for(input logic [N_W-1:0] n);
    case (range_class(n))
      1:       return 64 * int'(n);
      2:       return 32 * int'(n);
      3:       return 16 * int'(n);
      4:       return 8 * int'(n);
      default: return 0;
    endcase
  endfunction

  task automatic compare(input string what, input int expected, input int actual);
    if (expected != actual) begin
      $display("ERROR: %s %s expected %0d actual %0d", test_name, what, expected, actual);
      err_count++;
    end
  endtask

  //////////////////////////////////////////////////
  // host strobes

  task automatic write_n(input logic [N_W-1:0] value);
    @(posedge CLK);
    host.n_wr <= 1'b1;
    host.data <= value;
    @(posedge CLK);
    host.n_wr <= 1'b0;
  endtask

  task automatic write_mode(input logic ie);
    @(posedge CLK);
    host.md_wr <= 1'b1;
    host.data  <= N_W'(ie) << MD_TONE_IE_BIT;
    @(posedge CLK);
    host.md_wr <= 1'b0;
  endtask

  task automatic issue_reti();
    @(posedge CLK);
    host.reti <= 1'b1;
    @(posedge CLK);
    host.reti <= 1'b0;
  endtask

  // a range switch can leave one stray trig in flight
  task automatic drain_service();
    repeat (48) @(posedge CLK);
    issue_reti();
    repeat (24) @(posedge CLK);
  endtask

  task automatic await_load(input int limit);
    int start_count;
    int waited;
    start_count = load_count;
    waited      = 0;
    while (load_count == start_count && waited < limit) begin
      @(posedge CLK);
      waited++;
    end
    if (load_count == start_count) begin
      $display("%s: no rise of load within %0d cycles", test_name, limit);
      err_count++;
    end
  endtask

  // load edges and vector sampled away from the active edge
  always @(negedge CLK) begin
    cycle++;
    if (irq.load === 1'b1 && !load_seen) begin
      last_rise = cycle;
      load_count++;
      if (quiet) begin
        $display("%s: load rose while no interrupt was expected", test_name);
        err_count++;
      end
    end
    if (irq.load === 1'b1 && vec_chk && irq.vec !== exp_vec) begin
      $display("ERROR: %s vec expected %03h actual %03h", test_name, exp_vec, irq.vec);
      err_count++;
    end
    load_seen = (irq.load === 1'b1);
  end

  //////////////////////////////////////////////////
  // tests

  task automatic reset_test();
    int bad;
    bad       = 0;
    test_name = "reset";
    quiet     = 1'b1;
    repeat (16) @(posedge CLK);  // internal reset drops on a tick
    repeat (200) begin
      @(negedge CLK);
      if (irq.load !== 1'b0 || irq.active !== 1'b0 || irq.vec !== '0) begin
        bad++;
      end
    end
    compare("non-zero output cycles", 0, bad);
    quiet = 1'b0;
  endtask

  // first load may come from the range switch, so it is not timed
  task automatic interval_test(input int cls);
    logic [N_W-1:0] n;
    int             interval;
    int             rise [4];
    n         = pick_n(cls);
    interval  = interval_for(n);
    test_name = $sformatf("interval_n%02h", n);
    vec_chk   = 1'b0;
    write_n(n);
    repeat (24) @(posedge CLK);
    exp_vec = vec_for(n);
    vec_chk = 1'b1;
    for (int k = 0; k < 4; k++) begin
      await_load(NC_WRAP + 2 * interval + 64);
      rise[k] = last_rise;
      issue_reti();
    end
    compare("interval", interval, rise[2] - rise[1]);
    compare("interval", interval, rise[3] - rise[2]);
  endtask

  task automatic silence_test();
    logic [N_W-1:0] n;
    test_name = "no_irq_off";
    vec_chk   = 1'b0;
    write_n(pick_n(0));
    drain_service();
    quiet = 1'b1;
    repeat (NC_WRAP + 2 * LONGEST) @(posedge CLK);
    quiet     = 1'b0;
    test_name = "no_irq_ie_clear";
    write_mode(1'b0);
    drain_service();
    quiet = 1'b1;
    for (int cls = 1; cls <= 4; cls++) begin
      n = pick_n(cls);
      write_n(n);
      repeat (NC_WRAP + 2 * interval_for(n)) @(posedge CLK);
    end
    quiet = 1'b0;
  endtask

  task automatic blocking_test();
    logic [N_W-1:0] n;
    int             interval;
    int             first_rise;
    int             drops;
    n         = pick_n(4);
    interval  = interval_for(n);
    test_name = $sformatf("blocking_n%02h", n);
    write_n(n);
    repeat (24) @(posedge CLK);
    exp_vec = vec_for(n);
    vec_chk = 1'b1;
    write_mode(1'b1);
    repeat (2) begin
      await_load(NC_WRAP + 2 * interval + 64);
      issue_reti();
    end
    await_load(2 * interval + 64);
    first_rise = last_rise;
    quiet      = 1'b1;  // trigs are lost while held in service
    drops      = 0;
    repeat (3 * interval + interval / 2) begin
      @(negedge CLK);
      if (irq.active !== 1'b1) begin
        drops++;
      end
    end
    compare("active low cycles in service", 0, drops);
    quiet = 1'b0;
    issue_reti();
    await_load(2 * interval + 64);
    compare("interval across service", 4 * interval, last_rise - first_rise);
    first_rise = last_rise;
    issue_reti();
    await_load(2 * interval + 64);
    compare("interval after service", interval, last_rise - first_rise);
  endtask

  initial begin
    int assert_fails;
    CLK   = 1'b0;
    rst_n = 1'b0;
    host  = '0;
    repeat (16) @(posedge CLK);
    rst_n <= 1'b1;
    reset_test();
    write_mode(1'b1);
    for (int cls = 1; cls <= 4; cls++) begin
      interval_test(cls);
    end
    silence_test();
    blocking_test();
    assert_fails = i_dut.i_tone_int_ctrl.i_assertions.fail_count;
    $display("check errors: %0d, assertion failures: %0d", err_count, assert_fails);
    if (err_count == 0 && assert_fails == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

  initial begin
    repeat (WATCHDOG_CLK) @(posedge CLK);
    $display("watchdog expired after %0d cycles, the run did not finish", WATCHDOG_CLK);
    $display("Test failures found");
    $finish;
  end

endmodule

`default_nettype wire

/* vlog.f */
rtl/tone_pkg.sv
rtl/clock_phase_gen.sv
rtl/tone_divider.sv
rtl/tone_int_ctrl.sv
rtl/tone_timer_top.sv
tb/tone_timer_assertions.sv
tb/tone_timer_tb.sv

/* Makefile */
# each variable can be set on the make command line
VERILATOR ?= verilator
TOP       ?= tone_timer_tb
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
LINTFLAGS ?= --lint-only --timing -Wall
RUN_ARGS  ?= +verilator+error+limit+1000
FAIL_MSG  ?= Test failures found

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	./$(OBJ_DIR)/V$(TOP) $(RUN_ARGS) 2>&1 | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
	  echo "simulation failed, see $(LOG)"; exit 1; \
	elif ! grep -q "All tests passed!" $(LOG); then \
	  echo "simulation ended without a result, see $(LOG)"; exit 1; \
	fi

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
